// ==== bridge_pkg.sv ====
package bridge_pkg;

  // bus and index word widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int ORD_W  = 31;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // bit 31 marks an active core, the rest is its ring position
  typedef struct packed {
    logic             active;
    logic [ORD_W-1:0] ordinal;
  } cpu_index_t;

  // core states that matter to the bridge
  // read and write sub-states are folded into one code each
  typedef enum logic [2:0] {
    CORE_IDLE           = 3'd0,
    CORE_WAIT_FOR_START = 3'd1,
    CORE_READ_OPERAND   = 3'd2,
    CORE_WRITE_RESULT   = 3'd3,
    CORE_BREAK_THREAD   = 3'd4,
    CORE_FINISH_BEGIN   = 3'd5,
    CORE_FINISH_END     = 3'd6
  } core_state_t;

  // messages sent out to the ring
  typedef enum logic [3:0] {
    MSG_NONE         = 4'd0,
    MSG_RESET        = 4'd1,
    MSG_START        = 4'd2,
    MSG_END          = 4'd3,
    MSG_BREAK_THREAD = 4'd4
  } cpu_msg_t;

  // offered index vs own index
  typedef enum logic [1:0] {
    REL_NONE    = 2'b00,
    REL_LESS    = 2'b01,
    REL_GREATER = 2'b10,
    REL_EQUAL   = 2'b11
  } index_rel_t;

  typedef struct packed {
    addr_t addr;
    data_t data;
  } bus_word_t;

  // token offer from the ring
  typedef struct packed {
    logic       valid;
    cpu_index_t index;
  } token_offer_t;

endpackage

// ==== reset_sequencer.sv ====
`timescale 1ns/1ps

module reset_sequencer import bridge_pkg::*; (
  input  logic        clk,
  input  logic        ext_rst_b,
  input  core_state_t core_state,
  input  logic        holding,
  output logic        run,
  output logic        index_load,
  output logic        reset_msg,
  output logic        core_rst,
  output logic        ext_rst_e,
  output logic        ext_dispatcher_q
);

  // step codes, 6 unused
  localparam logic [2:0] STEP_1   = 3'd1;
  localparam logic [2:0] STEP_2   = 3'd2;
  localparam logic [2:0] STEP_3   = 3'd3;
  localparam logic [2:0] STEP_4   = 3'd4;
  localparam logic [2:0] STEP_5   = 3'd5;
  localparam logic [2:0] STEP_RUN = 3'd7;

  logic [2:0] step;
  logic [2:0] step_nxt;
  // set when step 3 was bypassed on FINISH_END
  logic       skipped;
  logic       skipped_nxt;

  always_comb begin
    step_nxt    = step;
    skipped_nxt = skipped;
    case (step)
      STEP_1: step_nxt = STEP_2;
      STEP_2: begin
        // finished core keeps its index, no load and no reset echo
        if (core_state == CORE_FINISH_END) begin
          step_nxt    = STEP_4;
          skipped_nxt = 1'b1;
        end else begin
          step_nxt    = STEP_3;
          skipped_nxt = 1'b0;
        end
      end
      STEP_3: step_nxt = STEP_4;
      STEP_4: step_nxt = STEP_5;
      STEP_5: step_nxt = STEP_RUN;
      STEP_RUN: begin
        // thread done and token gone, start over
        if (core_state == CORE_FINISH_END && !holding) begin
          step_nxt = STEP_1;
        end
      end
      default: step_nxt = STEP_1;
    endcase
  end

  // outputs registered from the next step
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      step             <= STEP_1;
      skipped          <= 1'b0;
      run              <= 1'b0;
      index_load       <= 1'b0;
      reset_msg        <= 1'b0;
      core_rst         <= 1'b0;
      ext_rst_e        <= 1'b0;
      ext_dispatcher_q <= 1'b0;
    end else begin
      step             <= step_nxt;
      skipped          <= skipped_nxt;
      run              <= (step_nxt == STEP_RUN);
      index_load       <= (step_nxt == STEP_3);
      reset_msg        <= (step_nxt == STEP_3);
      core_rst         <= (step_nxt == STEP_4);
      ext_rst_e        <= (step_nxt == STEP_4) && !skipped_nxt;
      // dispatcher request held from step 5 through run
      ext_dispatcher_q <= (step_nxt == STEP_5) || (step_nxt == STEP_RUN);
    end
  end

endmodule

// ==== no_data_timer.sv ====
`timescale 1ns/1ps

module no_data_timer #(
  parameter int unsigned NO_DATA_MAX = 8
) (
  input  logic clk,
  input  logic ext_rst_b,
  input  logic run,
  input  logic no_data_new,
  input  logic no_data_tick,
  output logic expired
);

  localparam int CNT_W = $clog2(NO_DATA_MAX + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (ext_rst_b || !run || no_data_new) begin
      // new data wins over a tick
      count   <= '0;
      expired <= 1'b0;
    end else if (no_data_tick) begin
      // saturate, then flag expiry
      if (count >= CNT_W'(NO_DATA_MAX)) begin
        expired <= 1'b1;
      end else begin
        count <= count + CNT_W'(1);
      end
    end
  end

endmodule

// ==== token_arbiter.sv ====
`timescale 1ns/1ps

module token_arbiter import bridge_pkg::*; (
  input  logic         clk,
  input  logic         ext_rst_b,
  input  logic         run,
  input  logic         index_load,
  input  token_offer_t offer,
  input  logic         bus_busy_in,
  input  logic         read_q,
  input  logic         write_q,
  input  core_state_t  core_state,
  input  logic         handoff_req,
  output logic         grant,
  output logic         disp_online,
  output cpu_index_t   own_index,
  output index_rel_t   index_rel,
  output logic         ext_next_cpu_e,
  output logic         ext_read_q,
  output logic         ext_write_q
);

  logic accept;
  logic release_req;
  // handoff waiting out back-pressure
  logic handoff_pend;

  // token is ours only on an exact index match
  assign accept = run && offer.valid && (offer.index == own_index)
                  && !bus_busy_in && !disp_online;

  assign release_req = handoff_req || handoff_pend
                       || (disp_online && (read_q || write_q));

  // own index latched once per reset sequence
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      own_index <= '0;
    end else if (index_load) begin
      own_index <= offer.index;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      grant          <= 1'b0;
      disp_online    <= 1'b0;
      ext_next_cpu_e <= 1'b0;
      handoff_pend   <= 1'b0;
    end else begin
      grant <= accept;
      // no new release under back-pressure, never two in a row
      ext_next_cpu_e <= release_req && !ext_next_cpu_e && !bus_busy_in;
      if (handoff_req && (bus_busy_in || ext_next_cpu_e)) begin
        handoff_pend <= 1'b1;
      end else if (!bus_busy_in && !ext_next_cpu_e) begin
        handoff_pend <= 1'b0;
      end
      if (accept) begin
        disp_online <= 1'b1;
      end else if (ext_next_cpu_e) begin
        // offline once the token is handed back
        disp_online <= 1'b0;
      end
    end
  end

  // relation flags follow every valid offer
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      index_rel <= REL_NONE;
    end else if (offer.valid) begin
      if (offer.index.ordinal < own_index.ordinal) begin
        index_rel <= REL_LESS;
      end else if (offer.index.ordinal > own_index.ordinal) begin
        index_rel <= REL_GREATER;
      end else if (offer.index == own_index) begin
        index_rel <= REL_EQUAL;
      end
    end else if (ext_next_cpu_e) begin
      index_rel <= REL_NONE;
    end
  end

  // core requests reach the bus only while online
  assign ext_read_q  = (disp_online && core_state == CORE_READ_OPERAND) ? read_q : 1'b0;
  assign ext_write_q = (disp_online && core_state == CORE_WRITE_RESULT) ? write_q : 1'b0;

endmodule

// ==== thread_context.sv ====
`timescale 1ns/1ps

module thread_context import bridge_pkg::*; #(
  parameter int unsigned HEADER_SPACE = 4
) (
  input  logic        clk,
  input  logic        ext_rst_b,
  input  logic        grant,
  input  logic        reset_msg,
  input  logic        expired,
  input  core_state_t core_state,
  input  bus_word_t   bus_in,
  output addr_t       base_addr,
  output addr_t       base_addr_data,
  output bus_word_t   bus_out,
  output cpu_msg_t    ext_cpu_msg,
  output logic        next_state,
  output logic        handoff_req
);

  localparam addr_t HDR_WORDS = addr_t'(HEADER_SPACE);

  // code base just past the thread header
  addr_t start_addr;

  assign start_addr = bus_in.addr + HDR_WORDS;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      base_addr      <= '0;
      base_addr_data <= '0;
      bus_out        <= '0;
      ext_cpu_msg    <= MSG_NONE;
      next_state     <= 1'b0;
      handoff_req    <= 1'b0;
    end else begin
      // message, break word and pulses last one cycle
      bus_out     <= '0;
      ext_cpu_msg <= MSG_NONE;
      next_state  <= 1'b0;
      handoff_req <= 1'b0;

      if (reset_msg) begin
        ext_cpu_msg <= MSG_RESET;
      end

      // stalled read gives up
      if (expired && core_state == CORE_READ_OPERAND) begin
        next_state <= 1'b1;
      end

      if (grant) begin
        case (core_state)
          CORE_WAIT_FOR_START: begin
            base_addr <= start_addr;
            // zero data word means data shares the code base
            if (bus_in.data == '0) begin
              base_addr_data <= start_addr;
            end else begin
              base_addr_data <= bus_in.data + HDR_WORDS;
            end
            ext_cpu_msg <= MSG_START;
            next_state  <= 1'b1;
            handoff_req <= 1'b1;
          end
          CORE_FINISH_BEGIN: begin
            ext_cpu_msg <= MSG_END;
            next_state  <= 1'b1;
            handoff_req <= 1'b1;
          end
          CORE_BREAK_THREAD: begin
            // hand back the header addresses of the thread
            ext_cpu_msg  <= MSG_BREAK_THREAD;
            bus_out.addr <= base_addr - HDR_WORDS;
            bus_out.data <= base_addr_data - HDR_WORDS;
            next_state   <= 1'b1;
            handoff_req  <= 1'b1;
          end
          default: begin
            // other states only use the token for bus access
          end
        endcase
      end
    end
  end

endmodule

// ==== bridge_to_outside.sv ====
`timescale 1ns/1ps

module bridge_to_outside import bridge_pkg::*; #(
  parameter int unsigned HEADER_SPACE = 4,
  parameter int unsigned NO_DATA_MAX  = 8
) (
  input  logic         clk,
  input  logic         ext_rst_b,
  input  core_state_t  core_state,
  input  logic         read_q,
  input  logic         write_q,
  input  logic         bus_busy_in,
  input  token_offer_t offer,
  input  bus_word_t    bus_in,
  input  logic         no_data_new,
  input  logic         no_data_tick,
  output logic         ext_read_q,
  output logic         ext_write_q,
  output logic         ext_next_cpu_e,
  output logic         ext_dispatcher_q,
  output logic         ext_rst_e,
  output logic         core_rst,
  output logic         disp_online,
  output index_rel_t   index_rel,
  output cpu_msg_t     ext_cpu_msg,
  output bus_word_t    bus_out,
  output addr_t        base_addr,
  output addr_t        base_addr_data,
  output logic         next_state
);

  // sequencer to datapath
  logic       run;
  logic       index_load;
  logic       reset_msg;
  // arbiter and context handshake
  logic       grant;
  logic       handoff_req;
  logic       expired;

  reset_sequencer i_reset_sequencer (
    .clk              (clk),
    .ext_rst_b        (ext_rst_b),
    .core_state       (core_state),
    .holding          (disp_online),
    .run              (run),
    .index_load       (index_load),
    .reset_msg        (reset_msg),
    .core_rst         (core_rst),
    .ext_rst_e        (ext_rst_e),
    .ext_dispatcher_q (ext_dispatcher_q)
  );

  no_data_timer #(
    .NO_DATA_MAX (NO_DATA_MAX)
  ) i_no_data_timer (
    .clk          (clk),
    .ext_rst_b    (ext_rst_b),
    .run          (run),
    .no_data_new  (no_data_new),
    .no_data_tick (no_data_tick),
    .expired      (expired)
  );

  token_arbiter i_token_arbiter (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .run            (run),
    .index_load     (index_load),
    .offer          (offer),
    .bus_busy_in    (bus_busy_in),
    .read_q         (read_q),
    .write_q        (write_q),
    .core_state     (core_state),
    .handoff_req    (handoff_req),
    .grant          (grant),
    .disp_online    (disp_online),
    .own_index      (),
    .index_rel      (index_rel),
    .ext_next_cpu_e (ext_next_cpu_e),
    .ext_read_q     (ext_read_q),
    .ext_write_q    (ext_write_q)
  );

  thread_context #(
    .HEADER_SPACE (HEADER_SPACE)
  ) i_thread_context (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .grant          (grant),
    .reset_msg      (reset_msg),
    .expired        (expired),
    .core_state     (core_state),
    .bus_in         (bus_in),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .bus_out        (bus_out),
    .ext_cpu_msg    (ext_cpu_msg),
    .next_state     (next_state),
    .handoff_req    (handoff_req)
  );

endmodule

// ==== bridge_assertions.sv ====
`timescale 1ns/1ps

module bridge_assertions (
  input logic clk,
  input logic ext_rst_b,
  input logic grant,
  input logic disp_online,
  input logic ext_next_cpu_e,
  input logic ext_read_q,
  input logic ext_write_q
);

  // release is a single pulse
  assert property (@(posedge clk) disable iff (ext_rst_b)
    ext_next_cpu_e |=> !ext_next_cpu_e)
    else $error("release pulse held two cycles");

  // a grant keeps the bridge online
  assert property (@(posedge clk) disable iff (ext_rst_b)
    grant |=> disp_online)
    else $error("offline right after grant");

  assert property (@(posedge clk) disable iff (ext_rst_b)
    !(ext_read_q && ext_write_q))
    else $error("read and write request together");

endmodule

bind token_arbiter bridge_assertions i_bridge_assertions (
  .clk            (clk),
  .ext_rst_b      (ext_rst_b),
  .grant          (grant),
  .disp_online    (disp_online),
  .ext_next_cpu_e (ext_next_cpu_e),
  .ext_read_q     (ext_read_q),
  .ext_write_q    (ext_write_q)
);

// ==== bridge_tb.sv ====
`timescale 1ns/1ps

module bridge_tb import bridge_pkg::*; ();

  // testbench copies of the DUT parameters
  localparam int unsigned HDR = 4;
  localparam int unsigned NDM = 8;
  localparam int MAX_WORDS = 6 * 32;

  logic         clk;
  logic         ext_rst_b;
  core_state_t  core_state;
  logic         read_q;
  logic         write_q;
  logic         bus_busy_in;
  token_offer_t offer;
  bus_word_t    bus_in;
  logic         no_data_new;
  logic         no_data_tick;
  logic         ext_read_q;
  logic         ext_write_q;
  logic         ext_next_cpu_e;
  logic         ext_dispatcher_q;
  logic         ext_rst_e;
  logic         core_rst;
  logic         disp_online;
  index_rel_t   index_rel;
  cpu_msg_t     ext_cpu_msg;
  bus_word_t    bus_out;
  addr_t        base_addr;
  addr_t        base_addr_data;
  logic         next_state;

  // six words per row, see bridge_vectors.mem
  logic [31:0] vec_mem [0:MAX_WORDS-1];
  int          num_rows;
  int          cycle_cnt;
  int          limit;
  int unsigned lcg_state;

  // reference model state
  cpu_index_t  own_idx;
  addr_t       exp_base;
  addr_t       exp_bdata;
  index_rel_t  exp_rel;

  bridge_to_outside #(
    .HEADER_SPACE (HDR),
    .NO_DATA_MAX  (NDM)
  ) i_bridge_to_outside (
    .clk              (clk),
    .ext_rst_b        (ext_rst_b),
    .core_state       (core_state),
    .read_q           (read_q),
    .write_q          (write_q),
    .bus_busy_in      (bus_busy_in),
    .offer            (offer),
    .bus_in           (bus_in),
    .no_data_new      (no_data_new),
    .no_data_tick     (no_data_tick),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .ext_next_cpu_e   (ext_next_cpu_e),
    .ext_dispatcher_q (ext_dispatcher_q),
    .ext_rst_e        (ext_rst_e),
    .core_rst         (core_rst),
    .disp_online      (disp_online),
    .index_rel        (index_rel),
    .ext_cpu_msg      (ext_cpu_msg),
    .bus_out          (bus_out),
    .base_addr        (base_addr),
    .base_addr_data   (base_addr_data),
    .next_state       (next_state)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic fail_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  // run length guard
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (limit > 0 && cycle_cnt > limit) begin
      $display("ERROR: timeout, run did not finish within %0d cycles", limit);
      fail_run();
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_msg(input cpu_msg_t got, input cpu_msg_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
      fail_run();
    end
  endtask

  task automatic check_rel(input index_rel_t got, input index_rel_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
      fail_run();
    end
  endtask

  task automatic check_word(input bus_word_t got, input bus_word_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      fail_run();
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      fail_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
      fail_run();
    end
  endtask

  // reset for 5 cycles, then walk the sequence steps
  task automatic do_reset(input core_state_t st, input logic [31:0] idx);
    ext_rst_b   = 1'b1;
    core_state  = st;
    offer       = '{valid: 1'b0, index: ~idx};
    read_q      = 1'b0;
    write_q     = 1'b0;
    repeat (5) @(negedge clk);
    ext_rst_b = 1'b0;
    for (int c = 1; c <= 6; c++) begin
      // step 4 carries reset echo, core reset and RESET message
      check_bit(ext_rst_e, c == 4, "ext_rst_e");
      check_bit(core_rst, c == 4, "core_rst");
      check_msg(ext_cpu_msg, (c == 4) ? MSG_RESET : MSG_NONE, "reset message");
      check_bit(ext_dispatcher_q, c >= 5, "ext_dispatcher_q");
      // own index only present at the step 3 load edge
      offer.index = (c == 3) ? idx : ~idx;
      @(negedge clk);
    end
    check_bit(disp_online, 1'b0, "online after reset");
    own_idx   = idx;
    exp_base  = '0;
    exp_bdata = '0;
    exp_rel   = REL_NONE;
  endtask

  // one valid offer that must not match
  task automatic offer_other(input logic [31:0] idx);
    cpu_index_t oi;
    oi          = idx;
    core_state  = CORE_IDLE;
    offer       = '{valid: 1'b1, index: oi};
    bus_in      = {lcg_next(), lcg_next()};
    @(negedge clk);
    if (oi.ordinal < own_idx.ordinal) begin
      exp_rel = REL_LESS;
    end else if (oi.ordinal > own_idx.ordinal) begin
      exp_rel = REL_GREATER;
    end
    offer.valid = 1'b0;
    check_rel(index_rel, exp_rel, "index relation");
  endtask

  // grant in a phase state, message one cycle later, then release
  task automatic grant_phase(input core_state_t st, input addr_t a, input data_t d);
    bus_word_t exp_out;
    cpu_msg_t  exp_msg;
    core_state = st;
    offer      = '{valid: 1'b1, index: own_idx};
    bus_in     = (st == CORE_WAIT_FOR_START) ? {a, d} : {lcg_next(), lcg_next()};
    @(negedge clk);
    offer.valid = 1'b0;
    exp_rel     = REL_EQUAL;
    check_bit(disp_online, 1'b1, "online after accept");
    check_rel(index_rel, exp_rel, "index relation on match");
    @(negedge clk);
    exp_out = '0;
    if (st == CORE_WAIT_FOR_START) begin
      exp_base  = a + HDR;
      exp_bdata = (d == '0) ? exp_base : d + HDR;
      exp_msg   = MSG_START;
    end else if (st == CORE_BREAK_THREAD) begin
      exp_out = {exp_base - HDR, exp_bdata - HDR};
      exp_msg = MSG_BREAK_THREAD;
    end else begin
      exp_msg = MSG_END;
    end
    check_msg(ext_cpu_msg, exp_msg, "phase message");
    check_bit(next_state, 1'b1, "next_state with message");
    check_addr(base_addr, exp_base, "base_addr");
    check_addr(base_addr_data, exp_bdata, "base_addr_data");
    check_word(bus_out, exp_out, "bus_out");
    @(negedge clk);
    check_bit(ext_next_cpu_e, 1'b1, "token release");
    check_msg(ext_cpu_msg, MSG_NONE, "message after one cycle");
    @(negedge clk);
    exp_rel = REL_NONE;
    check_bit(disp_online, 1'b0, "offline after release");
    check_bit(ext_next_cpu_e, 1'b0, "single release pulse");
    check_rel(index_rel, exp_rel, "relation cleared");
  endtask

  task automatic gate_requests(input core_state_t st);
    core_state = st;
    read_q     = 1'b1;
    write_q    = 1'b1;
    bus_in     = {lcg_next(), lcg_next()};
    #1;
    // offline, nothing reaches the bus
    check_bit(ext_read_q, 1'b0, "ext_read_q offline");
    check_bit(ext_write_q, 1'b0, "ext_write_q offline");
    read_q  = 1'b0;
    write_q = 1'b0;
    offer   = '{valid: 1'b1, index: own_idx};
    @(negedge clk);
    offer.valid = 1'b0;
    check_bit(disp_online, 1'b1, "online for requests");
    read_q  = 1'b1;
    write_q = 1'b1;
    #1;
    check_bit(ext_read_q, st == CORE_READ_OPERAND, "ext_read_q online");
    check_bit(ext_write_q, st == CORE_WRITE_RESULT, "ext_write_q online");
    @(negedge clk);
    check_bit(ext_next_cpu_e, 1'b1, "release on request");
    read_q  = 1'b0;
    write_q = 1'b0;
    #1;
    // still online here, requests dropped
    check_bit(ext_read_q, 1'b0, "ext_read_q follows read_q");
    check_bit(ext_write_q, 1'b0, "ext_write_q follows write_q");
    @(negedge clk);
    exp_rel = REL_NONE;
    check_bit(disp_online, 1'b0, "offline after request");
    check_bit(ext_next_cpu_e, 1'b0, "one release per request");
    check_rel(index_rel, exp_rel, "relation after request");
  endtask

  // tick the timer, optional no_data_new at tick new_at
  task automatic no_data_run(input int new_at, input int ticks);
    int   cnt;
    logic expd;
    core_state  = CORE_READ_OPERAND;
    no_data_new = 1'b1;
    @(negedge clk);
    cnt  = 0;
    expd = 1'b0;
    for (int i = 0; i < ticks; i++) begin
      no_data_new  = (i == new_at);
      no_data_tick = 1'b1;
      bus_in       = {lcg_next(), lcg_next()};
      @(negedge clk);
      if (i == new_at) begin
        cnt  = 0;
        expd = 1'b0;
      end else if (cnt >= NDM) begin
        expd = 1'b1;
      end else begin
        cnt = cnt + 1;
      end
    end
    no_data_new  = 1'b0;
    no_data_tick = 1'b0;
    @(negedge clk);
    check_bit(next_state, expd, "next_state on no-data timeout");
    // clear timer before the next row
    core_state  = CORE_IDLE;
    no_data_new = 1'b1;
    repeat (2) @(negedge clk);
    no_data_new = 1'b0;
  endtask

  initial begin
    ext_rst_b    = 1'b1;
    core_state   = CORE_IDLE;
    read_q       = 1'b0;
    write_q      = 1'b0;
    bus_busy_in  = 1'b0;
    offer        = '0;
    bus_in       = '0;
    no_data_new  = 1'b0;
    no_data_tick = 1'b0;
    cycle_cnt    = 0;
    limit        = 0;
    lcg_state    = 22;
    for (int i = 0; i < MAX_WORDS; i++) begin
      vec_mem[i] = '0;
    end
    $readmemh("bridge_vectors.mem", vec_mem);
    num_rows = 0;
    while (num_rows < MAX_WORDS / 6 && vec_mem[num_rows * 6] != 0) begin
      num_rows++;
    end
    limit = num_rows * 40;
    for (int r = 0; r < num_rows; r++) begin
      case (vec_mem[r * 6])
        32'd1: do_reset(core_state_t'(vec_mem[r * 6 + 1][2:0]), vec_mem[r * 6 + 2]);
        32'd2: grant_phase(core_state_t'(vec_mem[r * 6 + 1][2:0]), vec_mem[r * 6 + 3],
                           vec_mem[r * 6 + 4]);
        32'd3: offer_other(vec_mem[r * 6 + 2]);
        32'd4: gate_requests(core_state_t'(vec_mem[r * 6 + 1][2:0]));
        32'd5: no_data_run(int'(vec_mem[r * 6 + 3]), int'(vec_mem[r * 6 + 5]));
        default: begin
          $display("ERROR: row %0d has an unknown scenario code", r);
          fail_run();
        end
      endcase
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== bridge_vectors.mem ====
// code state offer_index addr data ticks, six hex words per row
// code 1 reset, 2 grant phase, 3 other offer, 4 request gating, 5 no-data (addr = new at)
1 1 80000005 0 0 0
3 0 80000002 0 0 0
3 0 80000009 0 0 0
2 1 80000005 00001000 00002000 0
2 4 80000005 0 0 0
2 1 80000005 00003000 00000000 0
2 5 80000005 0 0 0
4 2 80000005 0 0 0
4 3 80000005 0 0 0
5 2 0 ff 0 9
5 2 0 4 0 9
5 2 0 ff 0 8
1 1 00000003 0 0 0
3 0 00000001 0 0 0
3 0 80000003 0 0 0
2 1 00000003 00000100 00000008 0
2 4 00000003 0 0 0
0 0 0 0 0 0

// ==== flist.f ====
bridge_pkg.sv
reset_sequencer.sv
no_data_timer.sv
token_arbiter.sv
thread_context.sv
bridge_to_outside.sv
bridge_assertions.sv
bridge_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module bridge_tb -o bridge_sim
	./obj_dir/bridge_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
